// File: verilog/mem_pkg.sv
package mem_pkg;

  // bus widths
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int AXI_ID_W = 4;

  // read source, carried on arid and returned on rid
  typedef enum logic [AXI_ID_W-1:0] {
    SRC_FETCH = 4'd0,
    SRC_LOAD  = 4'd1
  } rd_src_e;

  // read arbiter, one outstanding read
  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_DATA = 2'd2
  } rd_state_e;

  // write buffer drain of the head entry
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_SEND = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

endpackage

// File: verilog/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter (
  input  logic                           aclk,
  input  logic                           i_rst_n,
  // instruction fetch port
  input  logic                           i_fetch_valid,
  input  logic [mem_pkg::ADDR_W-1:0]     i_fetch_addr,
  output logic                           o_fetch_ready,
  output logic                           o_fetch_rvalid,
  output logic [mem_pkg::DATA_W-1:0]     o_fetch_rdata,
  // data load port
  input  logic                           i_load_valid,
  input  logic [mem_pkg::ADDR_W-1:0]     i_load_addr,
  output logic                           o_load_ready,
  output logic                           o_load_rvalid,
  output logic [mem_pkg::DATA_W-1:0]     o_load_rdata,
  // ordering against posted stores
  input  logic                           i_wbuf_empty,
  // AXI read address
  output logic [mem_pkg::AXI_ID_W-1:0]   o_arid,
  output logic [mem_pkg::ADDR_W-1:0]     o_araddr,
  output logic                           o_arvalid,
  input  logic                           i_arready,
  // AXI read data
  input  logic [mem_pkg::AXI_ID_W-1:0]   i_rid,
  input  logic [mem_pkg::DATA_W-1:0]     i_rdata,
  input  logic                           i_rvalid,
  output logic                           o_rready,
  // perf events
  output logic                           o_fetch_accept,
  output logic                           o_load_accept,
  output logic                           o_read_stall
);
  import mem_pkg::*;

  rd_state_e         state_q;
  rd_src_e           src_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] rdata_q;
  logic              fetch_rvalid_q;
  logic              load_rvalid_q;
  logic              idle;
  logic              ar_done;
  logic              r_done;

  assign idle    = (state_q == RD_IDLE);
  assign ar_done = (state_q == RD_ADDR) && i_arready;
  assign r_done  = (state_q == RD_DATA) && i_rvalid;

  // reads wait for the store buffer to drain, load wins over fetch
  assign o_load_ready  = idle && i_wbuf_empty;
  assign o_fetch_ready = idle && i_wbuf_empty && !i_load_valid;

  assign o_load_accept  = i_load_valid && o_load_ready;
  assign o_fetch_accept = i_fetch_valid && o_fetch_ready;
  assign o_read_stall   = idle && (i_fetch_valid || i_load_valid) && !i_wbuf_empty;

  assign o_arid    = src_q;
  assign o_araddr  = addr_q;
  assign o_arvalid = (state_q == RD_ADDR);
  assign o_rready  = (state_q == RD_DATA);

  assign o_fetch_rvalid = fetch_rvalid_q;
  assign o_fetch_rdata  = rdata_q;
  assign o_load_rvalid  = load_rvalid_q;
  assign o_load_rdata   = rdata_q;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (o_load_accept || o_fetch_accept) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (ar_done) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_done) begin
            state_q <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // request held on AR until the handshake
  always_ff @(posedge aclk) begin
    if (o_load_accept) begin
      src_q  <= SRC_LOAD;
      addr_q <= i_load_addr;
    end else if (o_fetch_accept) begin
      src_q  <= SRC_FETCH;
      addr_q <= i_fetch_addr;
    end
  end

  always_ff @(posedge aclk) begin
    if (r_done) begin
      rdata_q <= i_rdata;
    end
  end

  // one-cycle return pulse, steered by rid
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_rvalid_q <= 1'b0;
      load_rvalid_q  <= 1'b0;
    end else begin
      fetch_rvalid_q <= r_done && (i_rid == SRC_FETCH);
      load_rvalid_q  <= r_done && (i_rid == SRC_LOAD);
    end
  end

endmodule

// File: verilog/write_buffer.sv
`timescale 1ns/1ns

module write_buffer #(
  parameter int WBUF_DEPTH = 4
) (
  input  logic                          aclk,
  input  logic                          i_rst_n,
  // store port from the core
  input  logic                          i_st_valid,
  input  logic [mem_pkg::ADDR_W-1:0]    i_st_addr,
  input  logic [mem_pkg::STRB_W-1:0]    i_st_strb,
  input  logic [mem_pkg::DATA_W-1:0]    i_st_data,
  output logic                          o_st_ready,
  // status and perf event
  output logic                          o_wbuf_empty,
  output logic                          o_store_accept,
  // AXI write address
  output logic [mem_pkg::ADDR_W-1:0]    o_awaddr,
  output logic                          o_awvalid,
  input  logic                          i_awready,
  // AXI write data
  output logic [mem_pkg::DATA_W-1:0]    o_wdata,
  output logic [mem_pkg::STRB_W-1:0]    o_wstrb,
  output logic                          o_wvalid,
  input  logic                          i_wready,
  // AXI write response
  input  logic                          i_bvalid,
  output logic                          o_bready
);
  import mem_pkg::*;

  localparam int PTR_W = $clog2(WBUF_DEPTH);

  logic [ADDR_W-1:0] addr_mem [WBUF_DEPTH];
  logic [STRB_W-1:0] strb_mem [WBUF_DEPTH];
  logic [DATA_W-1:0] data_mem [WBUF_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  wr_state_e         state_q;
  logic              awvalid_q;
  logic              wvalid_q;
  logic              aw_done;
  logic              w_done;

  assign full  = (count == (PTR_W + 1)'(WBUF_DEPTH));
  assign empty = (count == '0);

  assign o_st_ready     = !full;
  assign o_wbuf_empty   = empty;
  assign push           = i_st_valid && !full;
  assign o_store_accept = push;

  // head entry stays put until its B response pops it
  assign o_awaddr  = addr_mem[rd_ptr];
  assign o_wdata   = data_mem[rd_ptr];
  assign o_wstrb   = strb_mem[rd_ptr];
  assign o_awvalid = awvalid_q;
  assign o_wvalid  = wvalid_q;
  assign o_bready  = (state_q == WR_RESP);

  assign aw_done = !awvalid_q || i_awready;
  assign w_done  = !wvalid_q || i_wready;
  assign pop     = (state_q == WR_RESP) && i_bvalid;

  always_ff @(posedge aclk) begin
    if (push) begin
      addr_mem[wr_ptr] <= i_st_addr;
      strb_mem[wr_ptr] <= i_st_strb;
      data_mem[wr_ptr] <= i_st_data;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // AW and W go out together, each drops after its own handshake
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= WR_IDLE;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (!empty) begin
            state_q   <= WR_SEND;
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
          end
        end
        WR_SEND: begin
          if (i_awready) begin
            awvalid_q <= 1'b0;
          end
          if (i_wready) begin
            wvalid_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (i_bvalid) begin
            state_q <= WR_IDLE;
          end
        end
        default: begin
          state_q   <= WR_IDLE;
          awvalid_q <= 1'b0;
          wvalid_q  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: verilog/perf_counter.sv
`timescale 1ns/1ns

module perf_counter #(
  parameter int CNT_W = 16
) (
  input  logic             aclk,
  input  logic             i_rst_n,
  input  logic             i_fetch_accept,
  input  logic             i_load_accept,
  input  logic             i_store_accept,
  input  logic             i_read_stall,
  output logic [CNT_W-1:0] o_fetch_cnt,
  output logic [CNT_W-1:0] o_load_cnt,
  output logic [CNT_W-1:0] o_store_cnt,
  output logic [CNT_W-1:0] o_stall_cnt
);

  localparam int N_EV = 4;

  logic [N_EV-1:0]  ev;
  logic [CNT_W-1:0] cnt_q [N_EV];

  // event index matches the output order below
  assign ev = {i_read_stall, i_store_accept, i_load_accept, i_fetch_accept};

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < N_EV; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_EV; i++) begin
        // hold at all ones
        if (ev[i] && (cnt_q[i] != {CNT_W{1'b1}})) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign o_fetch_cnt = cnt_q[0];
  assign o_load_cnt  = cnt_q[1];
  assign o_store_cnt = cnt_q[2];
  assign o_stall_cnt = cnt_q[3];

endmodule

// File: verilog/core_mem_top.sv
`timescale 1ns/1ns

module core_mem_top #(
  parameter int WBUF_DEPTH = 4,
  parameter int CNT_W      = 16
) (
  input  logic                          aclk,
  input  logic                          i_rst_n,
  // fetch
  input  logic                          i_fetch_valid,
  input  logic [mem_pkg::ADDR_W-1:0]    i_fetch_addr,
  output logic                          o_fetch_ready,
  output logic                          o_fetch_rvalid,
  output logic [mem_pkg::DATA_W-1:0]    o_fetch_rdata,
  // load
  input  logic                          i_load_valid,
  input  logic [mem_pkg::ADDR_W-1:0]    i_load_addr,
  output logic                          o_load_ready,
  output logic                          o_load_rvalid,
  output logic [mem_pkg::DATA_W-1:0]    o_load_rdata,
  // store
  input  logic                          i_st_valid,
  input  logic [mem_pkg::ADDR_W-1:0]    i_st_addr,
  input  logic [mem_pkg::STRB_W-1:0]    i_st_strb,
  input  logic [mem_pkg::DATA_W-1:0]    i_st_data,
  output logic                          o_st_ready,
  // counters
  output logic [CNT_W-1:0]              o_fetch_cnt,
  output logic [CNT_W-1:0]              o_load_cnt,
  output logic [CNT_W-1:0]              o_store_cnt,
  output logic [CNT_W-1:0]              o_stall_cnt,
  // AXI read channels
  output logic [mem_pkg::AXI_ID_W-1:0]  o_arid,
  output logic [mem_pkg::ADDR_W-1:0]    o_araddr,
  output logic                          o_arvalid,
  input  logic                          i_arready,
  input  logic [mem_pkg::AXI_ID_W-1:0]  i_rid,
  input  logic [mem_pkg::DATA_W-1:0]    i_rdata,
  input  logic                          i_rvalid,
  output logic                          o_rready,
  // AXI write channels
  output logic [mem_pkg::ADDR_W-1:0]    o_awaddr,
  output logic                          o_awvalid,
  input  logic                          i_awready,
  output logic [mem_pkg::DATA_W-1:0]    o_wdata,
  output logic [mem_pkg::STRB_W-1:0]    o_wstrb,
  output logic                          o_wvalid,
  input  logic                          i_wready,
  input  logic                          i_bvalid,
  output logic                          o_bready
);

  logic wbuf_empty;
  logic fetch_accept;
  logic load_accept;
  logic read_stall;
  logic store_accept;

  read_arbiter read_arbiter_i (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_fetch_valid  (i_fetch_valid),
    .i_fetch_addr   (i_fetch_addr),
    .o_fetch_ready  (o_fetch_ready),
    .o_fetch_rvalid (o_fetch_rvalid),
    .o_fetch_rdata  (o_fetch_rdata),
    .i_load_valid   (i_load_valid),
    .i_load_addr    (i_load_addr),
    .o_load_ready   (o_load_ready),
    .o_load_rvalid  (o_load_rvalid),
    .o_load_rdata   (o_load_rdata),
    .i_wbuf_empty   (wbuf_empty),
    .o_arid         (o_arid),
    .o_araddr       (o_araddr),
    .o_arvalid      (o_arvalid),
    .i_arready      (i_arready),
    .i_rid          (i_rid),
    .i_rdata        (i_rdata),
    .i_rvalid       (i_rvalid),
    .o_rready       (o_rready),
    .o_fetch_accept (fetch_accept),
    .o_load_accept  (load_accept),
    .o_read_stall   (read_stall)
  );

  write_buffer #(
    .WBUF_DEPTH (WBUF_DEPTH)
  ) write_buffer_i (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_st_valid     (i_st_valid),
    .i_st_addr      (i_st_addr),
    .i_st_strb      (i_st_strb),
    .i_st_data      (i_st_data),
    .o_st_ready     (o_st_ready),
    .o_wbuf_empty   (wbuf_empty),
    .o_store_accept (store_accept),
    .o_awaddr       (o_awaddr),
    .o_awvalid      (o_awvalid),
    .i_awready      (i_awready),
    .o_wdata        (o_wdata),
    .o_wstrb        (o_wstrb),
    .o_wvalid       (o_wvalid),
    .i_wready       (i_wready),
    .i_bvalid       (i_bvalid),
    .o_bready       (o_bready)
  );

  perf_counter #(
    .CNT_W (CNT_W)
  ) perf_counter_i (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_fetch_accept (fetch_accept),
    .i_load_accept  (load_accept),
    .i_store_accept (store_accept),
    .i_read_stall   (read_stall),
    .o_fetch_cnt    (o_fetch_cnt),
    .o_load_cnt     (o_load_cnt),
    .o_store_cnt    (o_store_cnt),
    .o_stall_cnt    (o_stall_cnt)
  );

endmodule

// File: test/core_mem_properties.sv
`timescale 1ns/1ns

module core_mem_properties (
  input logic                        aclk,
  input logic                        i_rst_n,
  input logic                        i_arvalid,
  input logic [mem_pkg::ADDR_W-1:0]  i_araddr,
  input logic                        i_arready,
  input logic                        i_awvalid,
  input logic [mem_pkg::ADDR_W-1:0]  i_awaddr,
  input logic                        i_awready,
  input logic                        i_wvalid,
  input logic [mem_pkg::DATA_W-1:0]  i_wdata,
  input logic                        i_wready,
  input logic                        i_wbuf_empty,
  input logic                        i_fetch_rvalid,
  input logic                        i_load_rvalid
);

  int unsigned fail_count = 0;

  ar_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      $error("arvalid or araddr changed before arready");
      fail_count++;
    end

  aw_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
      $error("awvalid or awaddr changed before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata))
    else begin
      $error("wvalid or wdata changed before wready");
      fail_count++;
    end

  // read request accepted only with the store buffer drained
  ar_after_drain: assert property (@(posedge aclk) disable iff (!i_rst_n)
    $rose(i_arvalid) |-> $past(i_wbuf_empty))
    else begin
      $error("arvalid issued while the write buffer held stores");
      fail_count++;
    end

  rvalid_excl: assert property (@(posedge aclk) disable iff (!i_rst_n)
    !(i_fetch_rvalid && i_load_rvalid))
    else begin
      $error("fetch and load rvalid high together");
      fail_count++;
    end

endmodule

bind core_mem_top core_mem_properties core_mem_properties_i (
  .aclk           (aclk),
  .i_rst_n        (i_rst_n),
  .i_arvalid      (o_arvalid),
  .i_araddr       (o_araddr),
  .i_arready      (i_arready),
  .i_awvalid      (o_awvalid),
  .i_awaddr       (o_awaddr),
  .i_awready      (i_awready),
  .i_wvalid       (o_wvalid),
  .i_wdata        (o_wdata),
  .i_wready       (i_wready),
  .i_wbuf_empty   (wbuf_empty),
  .i_fetch_rvalid (o_fetch_rvalid),
  .i_load_rvalid  (o_load_rvalid)
);

// File: test/core_mem_tb.sv
`timescale 1ns/1ns

module core_mem_tb;
  import mem_pkg::*;

  localparam int N_ROWS     = 16;
  localparam int RST_CYCLES = 5;
  localparam int N_DLY      = 256;

  typedef enum logic [1:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_DUAL} op_e;

  // addr2 and exp2 are the load side of a dual row
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] addr2;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] exp2;
    logic              slow_b;
    logic              full;
  } row_t;

  logic                aclk;
  logic                i_rst_n;
  logic                i_fetch_valid, o_fetch_ready, o_fetch_rvalid;
  logic                i_load_valid, o_load_ready, o_load_rvalid;
  logic [ADDR_W-1:0]   i_fetch_addr, i_load_addr, i_st_addr, o_araddr, o_awaddr;
  logic [DATA_W-1:0]   o_fetch_rdata, o_load_rdata, i_st_data, i_rdata, o_wdata;
  logic                i_st_valid, o_st_ready;
  logic [STRB_W-1:0]   i_st_strb, o_wstrb;
  logic [15:0]         o_fetch_cnt, o_load_cnt, o_store_cnt, o_stall_cnt;
  logic [AXI_ID_W-1:0] o_arid, i_rid;
  logic                o_arvalid, i_arready, i_rvalid, o_rready;
  logic                o_awvalid, i_awready, o_wvalid, i_wready, i_bvalid, o_bready;

  // slave memory and bookkeeping
  logic [DATA_W-1:0]   mem [64];
  logic [67:0]         exp_wr [$];
  int unsigned         rd_dly [N_DLY];
  int unsigned         wr_dly [N_DLY];
  int                  rd_di = 0;
  int                  wr_di = 0;
  int                  st_count = 0;
  int                  b_count = 0;
  logic                slow_b;
  row_t                rows [N_ROWS];
  int                  n_rows = 0;

  core_mem_top #(.WBUF_DEPTH(4), .CNT_W(16)) core_mem_top_i (.*);

  initial begin : clock_gen
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic tick();
    @(posedge aclk);
    #10;
  endtask

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] addr2,
                         input logic [3:0] strb, input logic [31:0] data,
                         input logic [31:0] exp, input logic [31:0] exp2,
                         input logic slow, input logic full);
    rows[n_rows] = '{op, addr, addr2, strb, data, exp, exp2, slow, full};
    n_rows++;
  endtask

  task automatic run_reads(input logic fv, input logic [31:0] fa, input logic [31:0] fexp,
                           input logic lv, input logic [31:0] la, input logic [31:0] lexp);
    logic f_pend;
    logic l_pend;
    logic f_wait;
    logic l_wait;
    f_pend = fv;
    l_pend = lv;
    f_wait = fv;
    l_wait = lv;
    i_fetch_addr = fa;
    i_load_addr  = la;
    while (f_wait || l_wait) begin
      i_fetch_valid = f_pend;
      i_load_valid  = l_pend;
      @(negedge aclk);
      if ((f_pend && o_fetch_ready) || (l_pend && o_load_ready)) begin
        assert (b_count == st_count)
          else report_failure("read accepted before every store got its B response");
      end
      if (l_pend && o_load_ready) begin
        l_pend = 1'b0;
      end
      if (f_pend && o_fetch_ready) begin
        f_pend = 1'b0;
      end
      if (o_load_rvalid) begin
        assert (l_wait && !l_pend) else report_failure("load data returned without a request");
        check_hex("o_load_rdata", o_load_rdata, lexp);
        l_wait = 1'b0;
      end
      if (o_fetch_rvalid) begin
        // a pending load must come back first
        assert (f_wait && !f_pend && !l_wait)
          else report_failure("fetch data returned out of order or without a request");
        check_hex("o_fetch_rdata", o_fetch_rdata, fexp);
        f_wait = 1'b0;
      end
      tick();
    end
    i_fetch_valid = 1'b0;
    i_load_valid  = 1'b0;
  endtask

  task automatic run_store(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data, input logic exp_ready);
    logic first;
    logic done;
    first = 1'b1;
    done  = 1'b0;
    i_st_valid = 1'b1;
    i_st_addr  = addr;
    i_st_strb  = strb;
    i_st_data  = data;
    while (!done) begin
      @(negedge aclk);
      if (first) begin
        check_hex("o_st_ready", o_st_ready, exp_ready);
        first = 1'b0;
      end
      if (o_st_ready) begin
        exp_wr.push_back({addr, strb, data});
        st_count++;
        done = 1'b1;
      end
      tick();
    end
    i_st_valid = 1'b0;
  endtask

  initial begin : read_slave
    logic [AXI_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rid     = '0;
    i_rdata   = '0;
    forever begin
      tick();
      if (o_arvalid) begin
        id   = o_arid;
        addr = o_araddr;
        assert (addr < 256) else report_failure("read address outside the memory model");
        repeat (rd_dly[rd_di % N_DLY]) tick();
        i_arready = 1'b1;
        tick();
        i_arready = 1'b0;
        repeat (rd_dly[(rd_di + 1) % N_DLY]) tick();
        rd_di += 2;
        i_rid    = id;
        i_rdata  = mem[addr[7:2]];
        i_rvalid = 1'b1;
        tick();
        i_rvalid = 1'b0;
      end
    end
  end

  initial begin : write_slave
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [67:0]       exp;
    int unsigned       aw_d;
    int unsigned       w_d;
    i_awready = 1'b0;
    i_wready  = 1'b0;
    i_bvalid  = 1'b0;
    forever begin
      tick();
      if (o_awvalid) begin
        addr = o_awaddr;
        data = o_wdata;
        strb = o_wstrb;
        aw_d = wr_dly[wr_di % N_DLY];
        w_d  = wr_dly[(wr_di + 1) % N_DLY];
        fork
          begin
            repeat (aw_d) tick();
            i_awready = 1'b1;
            tick();
            i_awready = 1'b0;
          end
          begin
            repeat (w_d) tick();
            i_wready = 1'b1;
            tick();
            i_wready = 1'b0;
          end
        join
        assert (exp_wr.size() > 0) else report_failure("AXI write seen with no accepted store");
        exp = exp_wr.pop_front();
        check_hex("o_awaddr", addr, exp[67:36]);
        check_hex("o_wstrb", strb, exp[35:32]);
        check_hex("o_wdata", data, exp[31:0]);
        for (int b = 0; b < STRB_W; b++) begin
          if (strb[b]) begin
            mem[addr[7:2]][8*b +: 8] = data[8*b +: 8];
          end
        end
        repeat (slow_b ? 12 : wr_dly[(wr_di + 2) % N_DLY]) tick();
        wr_di += 3;
        i_bvalid = 1'b1;
        tick();
        i_bvalid = 1'b0;
        b_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (RST_CYCLES + N_ROWS * 20) @(posedge aclk);
    report_failure("Timeout: the stimulus table did not finish in time");
  end

  initial begin : property_watch
    wait (core_mem_top_i.core_mem_properties_i.fail_count != 0);
    report_failure("a bound AXI protocol assertion failed");
  end

  initial begin : main
    int n_fetch;
    int n_load;
    int n_store;
    void'($urandom(39));
    for (int i = 0; i < N_DLY; i++) begin
      rd_dly[i] = $urandom % 4;
      wr_dly[i] = $urandom % 4;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = (i * 4) ^ 32'hA5A5_0000;
    end
    n_fetch = 0;
    n_load  = 0;
    n_store = 0;
    slow_b  = 1'b0;
    i_rst_n       = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_addr  = '0;
    i_load_valid  = 1'b0;
    i_load_addr   = '0;
    i_st_valid    = 1'b0;
    i_st_addr     = '0;
    i_st_strb     = '0;
    i_st_data     = '0;

    // expected words follow addr ^ A5A50000 merged with earlier stores
    add_row(OP_FETCH, 'h10, 0, 0, 0, 'hA5A5_0010, 0, 0, 0);
    add_row(OP_STORE, 'h20, 0, 'b0011, 'h1234_5678, 0, 0, 0, 0);
    add_row(OP_LOAD,  'h20, 0, 0, 0, 'hA5A5_5678, 0, 0, 0);
    add_row(OP_DUAL,  'h30, 'h34, 0, 0, 'hA5A5_0030, 'hA5A5_0034, 0, 0);
    add_row(OP_STORE, 'h40, 0, 'b1111, 'hDEAD_BEEF, 0, 0, 1, 0);
    add_row(OP_STORE, 'h44, 0, 'b1100, 'hCAFE_0000, 0, 0, 1, 0);
    add_row(OP_STORE, 'h48, 0, 'b0101, 'h1122_3344, 0, 0, 1, 0);
    add_row(OP_STORE, 'h4C, 0, 'b1000, 'h9900_0000, 0, 0, 1, 0);
    add_row(OP_STORE, 'h50, 0, 'b1111, 'h0BAD_F00D, 0, 0, 1, 1);
    add_row(OP_LOAD,  'h44, 0, 0, 0, 'hCAFE_0044, 0, 0, 0);
    add_row(OP_FETCH, 'h48, 0, 0, 0, 'hA522_0044, 0, 0, 0);
    add_row(OP_DUAL,  'h50, 'h4C, 0, 0, 'h0BAD_F00D, 'h99A5_004C, 0, 0);
    add_row(OP_STORE, 'h40, 0, 'b0010, 'h0000_AB00, 0, 0, 0, 0);
    add_row(OP_LOAD,  'h40, 0, 0, 0, 'hDEAD_ABEF, 0, 0, 0);
    add_row(OP_LOAD,  'hFC, 0, 0, 0, 'hA5A5_00FC, 0, 0, 0);
    add_row(OP_FETCH, 'h40, 0, 0, 0, 'hDEAD_ABEF, 0, 0, 0);

    repeat (RST_CYCLES) @(posedge aclk);
    #10;
    i_rst_n = 1'b1;
    @(negedge aclk);
    check_hex("{o_arvalid,o_rready,o_awvalid,o_wvalid,o_bready}",
              {o_arvalid, o_rready, o_awvalid, o_wvalid, o_bready}, 0);
    check_hex("{o_fetch_rvalid,o_load_rvalid}", {o_fetch_rvalid, o_load_rvalid}, 0);
    check_hex("o_st_ready", o_st_ready, 1);
    check_hex("o_fetch_cnt", o_fetch_cnt, 0);
    check_hex("o_load_cnt", o_load_cnt, 0);
    check_hex("o_store_cnt", o_store_cnt, 0);
    check_hex("o_stall_cnt", o_stall_cnt, 0);
    tick();

    foreach (rows[r]) begin
      slow_b = rows[r].slow_b;
      n_fetch += (rows[r].op == OP_FETCH || rows[r].op == OP_DUAL);
      n_load  += (rows[r].op == OP_LOAD || rows[r].op == OP_DUAL);
      n_store += (rows[r].op == OP_STORE);
      case (rows[r].op)
        OP_FETCH: run_reads(1'b1, rows[r].addr, rows[r].exp, 1'b0, 0, 0);
        OP_LOAD:  run_reads(1'b0, 0, 0, 1'b1, rows[r].addr, rows[r].exp);
        OP_DUAL:  run_reads(1'b1, rows[r].addr, rows[r].exp, 1'b1, rows[r].addr2, rows[r].exp2);
        default:  run_store(rows[r].addr, rows[r].strb, rows[r].data, !rows[r].full);
      endcase
    end

    repeat (2) tick();
    @(negedge aclk);
    check_hex("o_fetch_cnt", o_fetch_cnt, n_fetch);
    check_hex("o_load_cnt", o_load_cnt, n_load);
    check_hex("o_store_cnt", o_store_cnt, n_store);
    assert (o_stall_cnt != 0) else report_failure("o_stall_cnt stayed zero after a store");
    assert (exp_wr.size() == 0) else report_failure("accepted stores never reached the bus");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
verilog/mem_pkg.sv
verilog/read_arbiter.sv
verilog/write_buffer.sv
verilog/perf_counter.sv
verilog/core_mem_top.sv
test/core_mem_properties.sv
test/core_mem_tb.sv
